/* ddr3_pkg.sv */
package ddr3_pkg;

    ////////////////////
    // Widths

    localparam int ROW_W  = 15;  // Row address
    localparam int COL_W  = 10;  // Column address
    localparam int BANK_W = 3;   // Eight banks
    localparam int DATA_W = 8;   // One x8 lane
    localparam int ADDR_W = 15;  // A[14:0] on the pins

    ////////////////////
    // Default timing, all in clk cycles

    localparam int T_RST_DEF  = 17;    // Reset pin held low
    localparam int T_INIT_DEF = 1024;  // Wait after reset release, before ZQCL
    localparam int T_RFC_DEF  = 90;    // Refresh to next command
    localparam int T_RCD_DEF  = 5;     // Activate to column command
    localparam int WL_DEF     = 5;     // Write latency, AL + CWL
    localparam int RL_DEF     = 5;     // Read latency, AL + CL
    localparam int T_WR_DEF   = 5;     // Write recovery before precharge

    localparam int BURST_BEATS  = 4;  // Strobe cycles per burst
    localparam int CAPTURE_BEAT = 1;  // Read byte is taken on this beat

    ////////////////////
    // Enums

    typedef enum logic [3:0] {
        reset_hold,
        init_wait,
        zq_cal,
        idle,
        refreshing,
        refresh_wait,
        activating,
        bank_active,
        col_cmd,
        latency_wait,
        burst,
        write_recovery,
        precharging
    } seq_state_t;

    // Commands handed from the FSM to the pin encoder
    typedef enum logic [2:0] {
        cmd_nop,
        cmd_zqcl,
        cmd_refresh,
        cmd_activate,
        cmd_write,
        cmd_read,
        cmd_precharge
    } dram_cmd_t;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_refresh
    } op_t;

endpackage

/* ddr3_sequencer.sv */
module ddr3_sequencer
    import ddr3_pkg::*;
#(
    parameter int T_RST  = T_RST_DEF,
    parameter int T_INIT = T_INIT_DEF,
    parameter int T_RFC  = T_RFC_DEF,
    parameter int T_RCD  = T_RCD_DEF,
    parameter int WL     = WL_DEF,
    parameter int RL     = RL_DEF,
    parameter int T_WR   = T_WR_DEF
) (
    input  logic              clk,
    input  logic              rst,
    // User request
    input  logic              req,
    input  op_t               op,
    input  logic [ROW_W-1:0]  row,
    input  logic [COL_W-1:0]  col,
    input  logic [BANK_W-1:0] bank,
    input  logic [DATA_W-1:0] wdata,
    input  logic              burst_done,  // Last beat from the data path
    output logic              ack,
    output logic              done,
    output logic              init_done,
    // DRAM control
    output logic              ddr_reset_n,
    output dram_cmd_t         cmd,
    output logic [ROW_W-1:0]  cmd_row,
    output logic [COL_W-1:0]  cmd_col,
    output logic [BANK_W-1:0] cmd_bank,
    // Data path control
    output logic              burst_start,
    output logic              burst_write,
    output logic [DATA_W-1:0] burst_wdata
);

    localparam int CNT_W = 16;  // Wide enough for T_INIT

    seq_state_t state;
    logic [CNT_W-1:0] cnt;  // Shared down-counter, loaded on state entry
    logic refresh_again;

    // Request fields latched at ack
    op_t op_q;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_q;
    logic [BANK_W-1:0] bank_q;
    logic [DATA_W-1:0] wdata_q;

    ////////////////////
    // Handshake

    assign ack = (state == idle) && req && init_done;
    assign refresh_again = req && (op == op_refresh);  // Still held when tRFC runs out

    always_ff @(posedge clk) begin
        if (ack) begin
            op_q    <= op;
            row_q   <= row;
            col_q   <= col;
            bank_q  <= bank;
            wdata_q <= wdata;
        end
    end

    ////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= reset_hold;
            cnt       <= CNT_W'(T_RST - 1);
            init_done <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;  // Pulse
            case (state)
                reset_hold: begin  // DRAM reset pin low
                    if (cnt == '0) begin
                        state <= init_wait;
                        cnt   <= CNT_W'(T_INIT - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                init_wait: begin
                    if (cnt == '0)
                        state <= zq_cal;
                    else
                        cnt <= cnt - 1'b1;
                end
                zq_cal: begin  // One ZQCL, then open for requests
                    state     <= idle;
                    init_done <= 1'b1;
                end
                idle: begin
                    if (ack) begin
                        if (op == op_refresh)  // Refresh first
                            state <= refreshing;
                        else
                            state <= activating;
                    end
                end
                refreshing: begin
                    state <= refresh_wait;
                    cnt   <= CNT_W'(T_RFC - 2);  // Next command T_RFC after this one
                end
                refresh_wait: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (refresh_again) begin
                        state <= refreshing;  // Back to back, no new ack
                    end else begin
                        state <= idle;
                        done  <= 1'b1;
                    end
                end
                activating: begin
                    state <= bank_active;
                    cnt   <= CNT_W'(T_RCD - 2);
                end
                bank_active: begin  // tRCD
                    if (cnt == '0)
                        state <= col_cmd;
                    else
                        cnt <= cnt - 1'b1;
                end
                col_cmd: begin
                    state <= latency_wait;
                    // Reads and writes share the wait, only the length differs
                    cnt   <= (op_q == op_read) ? CNT_W'(RL - 1) : CNT_W'(WL - 1);
                end
                latency_wait: begin
                    if (cnt == '0)
                        state <= burst;
                    else
                        cnt <= cnt - 1'b1;
                end
                burst: begin  // Data path counts the beats
                    if (burst_done) begin
                        state <= write_recovery;
                        cnt   <= CNT_W'(T_WR - 2);
                    end
                end
                write_recovery: begin
                    if (cnt == '0)
                        state <= precharging;
                    else
                        cnt <= cnt - 1'b1;
                end
                precharging: begin
                    state <= idle;
                    done  <= 1'b1;
                end
                default: state <= reset_hold;
            endcase
        end
    end

    assign ddr_reset_n = (state != reset_hold);

    ////////////////////
    // Command select

    always_comb begin
        case (state)
            zq_cal:      cmd = cmd_zqcl;
            refreshing:  cmd = cmd_refresh;
            activating:  cmd = cmd_activate;
            col_cmd:     cmd = (op_q == op_read) ? cmd_read : cmd_write;
            precharging: cmd = cmd_precharge;
            default:     cmd = cmd_nop;
        endcase
    end

    assign cmd_row  = row_q;
    assign cmd_col  = col_q;
    assign cmd_bank = bank_q;

    assign burst_start = (state == latency_wait) && (cnt == '0);  // Last latency cycle
    assign burst_write = (op_q == op_write);
    assign burst_wdata = wdata_q;

    ////////////////////
    // Checks

    // Every ack moves the FSM out of idle on the next edge
    a_ack_idle: assert property (@(posedge clk) disable iff (rst)
        ack |-> (state == idle) ##1 (state != idle));

    // No request is taken until ZQ calibration has gone out
    a_no_early_ack: assert property (@(posedge clk) disable iff (rst)
        (state inside {reset_hold, init_wait, zq_cal}) |-> !ack && !init_done);

    // Burst starts only from the latency wait and ends on the data path's last beat
    a_burst_from_wait: assert property (@(posedge clk) disable iff (rst)
        burst_start |-> (state == latency_wait) ##BURST_BEATS burst_done);

endmodule

/* ddr3_cmd_encode.sv */
module ddr3_cmd_encode
    import ddr3_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  dram_cmd_t         cmd,
    input  logic [ROW_W-1:0]  cmd_row,
    input  logic [COL_W-1:0]  cmd_col,
    input  logic [BANK_W-1:0] cmd_bank,
    output logic              cs_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic [ADDR_W-1:0] addr,
    output logic [BANK_W-1:0] ba,
    output logic              dm
);

    localparam logic [ADDR_W-1:0] A10_HIGH = ADDR_W'(1) << 10;  // All banks, or ZQ long

    dram_cmd_t cmd_q;
    logic [3:0] pins;  // {cs_n, ras_n, cas_n, we_n}

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_q <= cmd_nop;
            dm    <= 1'b1;  // Masked until a column command
        end else begin
            cmd_q <= cmd;
            case (cmd)
                cmd_write, cmd_read:         dm <= 1'b0;
                cmd_activate, cmd_precharge: dm <= 1'b1;
                default: ;
            endcase
        end
    end

    // Address and bank ride along with the command
    always_ff @(posedge clk) begin
        ba <= cmd_bank;
        case (cmd)
            cmd_activate: addr <= ADDR_W'(cmd_row);
            // A10 low for no auto precharge, A12 low for BC4
            cmd_write, cmd_read: addr <= ADDR_W'(cmd_col);
            cmd_precharge, cmd_refresh, cmd_zqcl: addr <= A10_HIGH;
            default: ;  // Hold last value on NOP
        endcase
    end

    ////////////////////
    // JEDEC pin decode

    always_comb begin
        case (cmd_q)
            cmd_nop:       pins = 4'b0111;
            cmd_zqcl:      pins = 4'b0110;
            cmd_refresh:   pins = 4'b0001;
            cmd_activate:  pins = 4'b0011;
            cmd_write:     pins = 4'b0100;
            cmd_read:      pins = 4'b0101;
            cmd_precharge: pins = 4'b0010;
            default:       pins = 4'b1111;  // Deselect
        endcase
    end

    assign {cs_n, ras_n, cas_n, we_n} = pins;

    // Sequencer only ever hands over legal commands
    a_cs_low: assert property (@(posedge clk) disable iff (rst) !cs_n);

endmodule

/* ddr3_data_path.sv */
module ddr3_data_path
    import ddr3_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              burst_start,
    input  logic              burst_write,
    input  logic [DATA_W-1:0] burst_wdata,
    input  logic [DATA_W-1:0] dq_in,
    output logic              burst_done,
    output logic [DATA_W-1:0] dq_out,
    output logic              dq_oe,
    output logic              dqs_out,
    output logic              dqs_oe,
    output logic [DATA_W-1:0] rdata
);

    localparam int BEAT_W = $clog2(BURST_BEATS + 1);

    logic active;  // Burst in progress
    logic wr_q;    // Direction of the current burst
    logic [BEAT_W-1:0] beat;
    logic last_beat;

    assign last_beat  = active && (beat == BEAT_W'(BURST_BEATS - 1));
    assign burst_done = last_beat;

    ////////////////////
    // Beat counter and strobe

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            wr_q    <= 1'b0;
            beat    <= '0;
            dqs_out <= 1'b0;
        end else if (burst_start) begin
            active  <= 1'b1;
            wr_q    <= burst_write;
            beat    <= '0;
            dqs_out <= 1'b1;  // First beat high
        end else if (active) begin
            beat    <= beat + 1'b1;
            dqs_out <= ~dqs_out;  // Toggle each beat
            if (last_beat) begin
                active  <= 1'b0;
                dqs_out <= 1'b0;  // Park low after the burst
            end
        end
    end

    assign dqs_oe = active;
    assign dq_oe  = active && wr_q;  // DQ is driven on writes only

    ////////////////////
    // Data

    // Write byte is held for every beat of the burst
    always_ff @(posedge clk) begin
        if (burst_start && burst_write)
            dq_out <= burst_wdata;
    end

    always_ff @(posedge clk) begin
        if (active && !wr_q && (beat == BEAT_W'(CAPTURE_BEAT)))
            rdata <= dq_in;  // One byte per read
    end

    // A read burst never turns the DQ drivers on
    a_no_dq_on_read: assert property (@(posedge clk) disable iff (rst)
        (burst_start && !burst_write) |=> !dq_oe [*BURST_BEATS]);

endmodule

/* ddr3_ctrl_top.sv */
module ddr3_ctrl_top
    import ddr3_pkg::*;
#(
    parameter int T_RST  = T_RST_DEF,
    parameter int T_INIT = T_INIT_DEF,
    parameter int T_RFC  = T_RFC_DEF,
    parameter int T_RCD  = T_RCD_DEF,
    parameter int WL     = WL_DEF,
    parameter int RL     = RL_DEF,
    parameter int T_WR   = T_WR_DEF
) (
    input  logic              clk,
    input  logic              rst,
    // User side
    input  logic              req,
    input  op_t               op,
    input  logic [ROW_W-1:0]  row,
    input  logic [COL_W-1:0]  col,
    input  logic [BANK_W-1:0] bank,
    input  logic [DATA_W-1:0] wdata,
    output logic              ack,
    output logic              done,
    output logic [DATA_W-1:0] rdata,
    output logic              init_done,
    // DRAM side
    output logic              ddr_reset_n,
    output logic              cs_n,
    output logic              ras_n,
    output logic              cas_n,
    output logic              we_n,
    output logic [ADDR_W-1:0] addr,
    output logic [BANK_W-1:0] ba,
    output logic              dm,
    output logic [DATA_W-1:0] dq_out,
    output logic              dq_oe,
    input  logic [DATA_W-1:0] dq_in,
    output logic              dqs_out,
    output logic              dqs_oe
);

    // Sequencer to encoder
    dram_cmd_t cmd;
    logic [ROW_W-1:0] cmd_row;
    logic [COL_W-1:0] cmd_col;
    logic [BANK_W-1:0] cmd_bank;

    // Sequencer to data path
    logic burst_start;
    logic burst_write;
    logic burst_done;
    logic [DATA_W-1:0] burst_wdata;

    ddr3_sequencer #(
        .T_RST  (T_RST),
        .T_INIT (T_INIT),
        .T_RFC  (T_RFC),
        .T_RCD  (T_RCD),
        .WL     (WL),
        .RL     (RL),
        .T_WR   (T_WR)
    ) u_seq (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .op          (op),
        .row         (row),
        .col         (col),
        .bank        (bank),
        .wdata       (wdata),
        .burst_done  (burst_done),
        .ack         (ack),
        .done        (done),
        .init_done   (init_done),
        .ddr_reset_n (ddr_reset_n),
        .cmd         (cmd),
        .cmd_row     (cmd_row),
        .cmd_col     (cmd_col),
        .cmd_bank    (cmd_bank),
        .burst_start (burst_start),
        .burst_write (burst_write),
        .burst_wdata (burst_wdata)
    );

    ddr3_cmd_encode u_enc (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_row  (cmd_row),
        .cmd_col  (cmd_col),
        .cmd_bank (cmd_bank),
        .cs_n     (cs_n),
        .ras_n    (ras_n),
        .cas_n    (cas_n),
        .we_n     (we_n),
        .addr     (addr),
        .ba       (ba),
        .dm       (dm)
    );

    ddr3_data_path u_dp (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .burst_write (burst_write),
        .burst_wdata (burst_wdata),
        .dq_in       (dq_in),
        .burst_done  (burst_done),
        .dq_out      (dq_out),
        .dq_oe       (dq_oe),
        .dqs_out     (dqs_out),
        .dqs_oe      (dqs_oe),
        .rdata       (rdata)
    );

endmodule

/* tb_ddr3_ctrl.sv */
module tb_ddr3_ctrl
    import ddr3_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int T_RST  = 17;
    localparam int T_INIT = 8;
    localparam int T_RFC  = 20;
    localparam int T_RCD  = 5;
    localparam int WL     = 5;
    localparam int RL     = 5;
    localparam int T_WR   = 5;
    localparam int KEY_W  = BANK_W + ROW_W + COL_W;  // {bank, row, col}
    localparam int N_RAND = 20;
    localparam int HOLD_CYC = T_RFC + T_RFC / 2;  // Drops req inside the second tRFC wait

    // Worst case per operation, in clk cycles
    localparam int INIT_CYC  = 3 + T_RST + T_INIT + 4;
    localparam int RW_CYC    = T_RCD + ((WL > RL) ? WL : RL) + BURST_BEATS + T_WR + 8;
    localparam int REF_CYC   = 3 * T_RFC + 4;
    localparam int WATCH_CYC = INIT_CYC + (N_RAND + 2) * RW_CYC + 2 * REF_CYC;

    typedef struct {
        op_t              op;
        logic [KEY_W-1:0] key;
        logic [DATA_W-1:0] data;
        int               nref;  // Refresh commands expected before done
    } pend_t;

    // DUT ports
    logic clk = 1'b0;
    logic rst;
    logic req;
    op_t op;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [BANK_W-1:0] bank;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] dq_in = '0;
    logic ack;
    logic done;
    logic [DATA_W-1:0] rdata;
    logic init_done;
    logic ddr_reset_n;
    logic cs_n;
    logic ras_n;
    logic cas_n;
    logic we_n;
    logic [ADDR_W-1:0] addr;
    logic [BANK_W-1:0] ba;
    logic dm;
    logic [DATA_W-1:0] dq_out;
    logic dq_oe;
    logic dqs_out;
    logic dqs_oe;

    // Scoreboard
    pend_t pend_q[$];                 // Acked, waiting for done
    dram_cmd_t cmd_log[$];            // Pin commands since the last done
    logic [KEY_W-1:0] hist_key[$];    // Finished writes, oldest first
    logic [DATA_W-1:0] hist_data[$];
    logic [DATA_W-1:0] mem [logic [KEY_W-1:0]];  // DRAM model storage
    integer seed = 32'hc518_2513;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cyc = 0;           // Cycles since rst fell
    int rst_low_cyc = 0;
    int zq_cnt = 0;
    int ack_cnt = 0;
    int done_cnt = 0;
    int n_req = 0;
    int n_rw = 0;          // Writes and reads, one burst each
    int bursts = 0;
    int beat_run = 0;
    int act_cyc = -1000;
    int ref_cyc = -1000;
    logic [ROW_W-1:0] act_row = '0;
    logic [KEY_W-1:0] cur_key = '0;  // Address of the open column access
    logic [DATA_W-1:0] rd_byte = '0;
    logic col_is_write = 1'b0;
    logic dqs_prev = 1'b0;
    logic done_q = 1'b0;               // done on the previous falling edge
    logic [DATA_W-1:0] rdata_done = '0;  // rdata while done was high

    always #(CLK_PERIOD / 2) clk = ~clk;

    ddr3_ctrl_top #(
        .T_RST  (T_RST),
        .T_INIT (T_INIT),
        .T_RFC  (T_RFC),
        .T_RCD  (T_RCD),
        .WL     (WL),
        .RL     (RL),
        .T_WR   (T_WR)
    ) uut (.*);

    ////////////////////
    // Helpers

    task automatic value_error(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("ERROR %0t %s: got 'h%0h, expected 'h%0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic note_error(input string msg);
        $display("Problem at %0t: %s", $time, msg);
        errors++;
    endtask

    // JEDEC truth table, {cs_n, ras_n, cas_n, we_n}
    function automatic dram_cmd_t pin_cmd(input logic [3:0] pins);
        dram_cmd_t c;
        case (pins)
            4'b0110: c = cmd_zqcl;
            4'b0001: c = cmd_refresh;
            4'b0011: c = cmd_activate;
            4'b0100: c = cmd_write;
            4'b0101: c = cmd_read;
            4'b0010: c = cmd_precharge;
            default: c = cmd_nop;
        endcase
        return c;
    endfunction

    // Expected read byte from the history of finished writes
    function automatic logic [DATA_W-1:0] ref_rdata(input logic [KEY_W-1:0] key);
        logic [DATA_W-1:0] val;
        val = '0;  // Never written reads zero
        foreach (hist_key[i])
            if (hist_key[i] == key)
                val = hist_data[i];  // Latest write wins
        return val;
    endfunction

    function automatic logic [KEY_W-1:0] rand_key();
        logic [31:0] r;
        r = $random(seed);
        return r[KEY_W-1:0];
    endfunction

    // Present one request, hold it until ack, then optionally keep req up
    task automatic issue(input op_t o, input logic [KEY_W-1:0] key,
                         input logic [DATA_W-1:0] d, input int hold);
        pend_t p;
        @(negedge clk);
        req = 1'b1;
        op = o;
        {bank, row, col} = key;
        wdata = d;
        @(posedge clk);
        while (!ack)
            @(posedge clk);  // Waits out a busy sequencer
        p.op = o;
        p.key = key;
        p.data = d;
        p.nref = (hold > 0) ? 2 : 1;
        pend_q.push_back(p);
        n_req++;
        if (o != op_refresh)
            n_rw++;
        repeat (hold) @(posedge clk);
        @(negedge clk);
        req = 1'b0;
    endtask

    task automatic drain();
        while (pend_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic test_done(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s failed with %0d errors", name, errors - mark);
        end
    endtask

    ////////////////////
    // Pin monitor and DRAM model

    always @(posedge clk) begin
        dram_cmd_t pc;
        if (!rst) begin
            cyc++;
            if (!ddr_reset_n)
                rst_low_cyc++;
            if (ack)
                ack_cnt++;
            pc = pin_cmd({cs_n, ras_n, cas_n, we_n});
            if (pc != cmd_nop) begin
                assert (cyc - ref_cyc >= T_RFC) else
                    value_error("refresh to next command cycles", cyc - ref_cyc, T_RFC);
                if (pc != cmd_zqcl)
                    cmd_log.push_back(pc);
            end
            case (pc)
                cmd_zqcl:    zq_cnt++;
                cmd_refresh: ref_cyc = cyc;
                cmd_activate: begin
                    act_cyc = cyc;
                    act_row = addr[ROW_W-1:0];  // Row rides on A[14:0]
                end
                cmd_write, cmd_read: begin
                    assert (cyc - act_cyc >= T_RCD) else
                        value_error("activate to column cycles", cyc - act_cyc, T_RCD);
                    cur_key = {ba, act_row, addr[COL_W-1:0]};
                    rd_byte = mem.exists(cur_key) ? mem[cur_key] : '0;
                    col_is_write = (pc == cmd_write);
                end
                default: ;
            endcase
            // Strobe must flip on every beat
            if (dqs_oe) begin
                assert (dqs_out != dqs_prev) else
                    note_error("strobe held its level inside a burst");
                beat_run++;
            end else if (beat_run != 0) begin
                assert (beat_run == BURST_BEATS) else
                    value_error("dqs_oe burst length", beat_run, BURST_BEATS);
                bursts++;
                beat_run = 0;
            end
            assert (!dq_oe || (dqs_oe && col_is_write)) else
                note_error("dq_oe was high outside a write burst");
            if (dq_oe)
                mem[cur_key] = dq_out;  // Store the write byte
            dqs_prev = dqs_out;
        end
    end

    // Read data for every beat of a read burst
    always @(negedge clk)
        dq_in <= (dqs_oe && !col_is_write) ? rd_byte : '0;

    ////////////////////
    // Checker, once per done

    // Precharge shares the cycle with done and reaches the log one edge later
    always @(negedge clk) begin
        pend_t p;
        int n;
        dram_cmd_t col_exp;
        if (!rst && done_q) begin
            done_cnt++;
            if (pend_q.size() == 0) begin
                note_error("done pulsed with no request outstanding");
            end else begin
                p = pend_q.pop_front();
                if (p.op == op_refresh) begin
                    n = 0;
                    foreach (cmd_log[i])
                        if (cmd_log[i] == cmd_refresh)
                            n++;
                    assert (n == p.nref && n == cmd_log.size()) else
                        value_error("refresh commands", cmd_log.size(), p.nref);
                end else begin
                    col_exp = (p.op == op_read) ? cmd_read : cmd_write;
                    assert (cmd_log.size() == 3 && cmd_log[0] == cmd_activate &&
                            cmd_log[1] == col_exp && cmd_log[2] == cmd_precharge) else
                        note_error($sformatf("pin commands out of order for a %s",
                                             (p.op == op_read) ? "read" : "write"));
                    assert (cur_key == p.key) else
                        value_error("pin address {ba,row,col}", 32'(cur_key), 32'(p.key));
                    if (p.op == op_write) begin
                        hist_key.push_back(p.key);
                        hist_data.push_back(p.data);
                    end else begin
                        assert (rdata_done == ref_rdata(p.key)) else
                            value_error("rdata", 32'(rdata_done), 32'(ref_rdata(p.key)));
                    end
                end
            end
            cmd_log.delete();
        end
        done_q = done;
        rdata_done = rdata;
    end

    ////////////////////
    // Stimulus

    initial begin
        int mark;
        logic [KEY_W-1:0] key;
        logic [KEY_W-1:0] pool [4];  // Small address set so reads hit writes
        logic [31:0] r;
        rst = 1'b1;
        req = 1'b0;
        op = op_write;
        row = '0;
        col = '0;
        bank = '0;
        wdata = '0;

        // Reset, init wait and ZQ calibration
        mark = errors;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert ({cs_n, ras_n, cas_n, we_n} == 4'b0111 && dm && !ack && !done &&
                !init_done && !dq_oe && !dqs_oe) else
            note_error("outputs not at their reset levels while rst is high");
        rst = 1'b0;
        while (!init_done)
            @(posedge clk);
        repeat (2) @(negedge clk);
        assert (rst_low_cyc == T_RST) else
            value_error("ddr_reset_n low cycles", rst_low_cyc, T_RST);
        assert (zq_cnt == 1) else
            value_error("ZQCL commands", zq_cnt, 1);
        test_done("reset", mark);

        mark = errors;
        key = rand_key();
        r = $random(seed);
        issue(op_write, key, r[DATA_W-1:0], 0);
        issue(op_read, key, '0, 0);  // Same address straight back
        drain();
        test_done("write_read", mark);

        mark = errors;
        issue(op_refresh, '0, '0, 0);
        drain();
        test_done("refresh", mark);

        mark = errors;
        issue(op_refresh, '0, '0, HOLD_CYC);  // req held, second refresh without ack
        drain();
        test_done("refresh_b2b", mark);

        mark = errors;
        foreach (pool[i])
            pool[i] = rand_key();
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            issue(r[0] ? op_read : op_write, pool[r[2:1]], r[10:3], 0);
        end
        drain();
        assert (ack_cnt == n_req) else
            value_error("ack pulses", ack_cnt, n_req);
        assert (done_cnt == n_req) else
            value_error("done pulses", done_cnt, n_req);
        test_done("random", mark);

        mark = errors;
        assert (bursts == n_rw) else
            value_error("data bursts", bursts, n_rw);
        test_done("bursts", mark);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * WATCH_CYC);
        $display("Run did not finish within %0d cycles, a handshake never came", WATCH_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* vlog.f */
ddr3_pkg.sv
ddr3_sequencer.sv
ddr3_cmd_encode.sv
ddr3_data_path.sv
ddr3_ctrl_top.sv
tb_ddr3_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DDR3 sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_ddr3_ctrl -f vlog.f

out="$(./obj_dir/Vtb_ddr3_ctrl)"
echo "$out"

if grep -qx "SIMULATION PASSED" <<< "$out"; then
    exit 0
fi
exit 1
